// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP = mem_stage_tb
FILELIST = list.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/mem_stage_tb.sv ====
module mem_stage_tb
    import mem_stage_pkg::*;
;
    localparam int wait_limit = 200;
    localparam logic [31:0] test_pc = 32'hbfc0_0040;

    typedef struct {
        string       name;
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        // interrupt, overflow, carried exception
        logic [2:0]  faults;
        exc_code_e   exc_code_in;
        logic [31:0] exp_data;
        logic        exp_exc;
        exc_code_e   exp_code;
        logic [31:0] exp_badvaddr;
        int          exp_reads;
        int          exp_writes;
        int          stall;
    } test_entry_t;

    logic clk = 1'b0;
    logic reset;
    logic req_valid;
    logic req_ready;
    mem_op_e req_op;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [31:0] req_pc;
    logic req_overflow;
    logic req_exc_in;
    exc_code_e req_exc_code_in;
    logic interrupt;
    logic resp_valid;
    logic resp_ready;
    logic [31:0] resp_rdata;
    logic resp_exception;
    exc_code_e resp_exc_code;
    logic [31:0] resp_badvaddr;
    logic bus_rd_req;
    logic bus_wr_req;
    logic [31:0] bus_addr;
    logic [3:0] bus_wstrb;
    logic [31:0] bus_wdata;
    logic [31:0] bus_rdata = 32'h0;
    logic bus_data_ok = 1'b0;

    // bus memory model state
    logic [31:0] mem [logic [31:0]];
    int rd_count = 0;
    int wr_count = 0;
    bit pending = 1'b0;
    int wait_left = 0;

    test_entry_t tests[$];
    int cur_index;
    string cur_name;
    bit test_bad;
    int pass_count = 0;
    int fail_count = 0;
    bit timed_out = 1'b0;

    mem_stage u_dut (
        .clk, .reset, .req_valid, .req_ready, .req_op, .req_addr, .req_wdata, .req_pc,
        .req_overflow, .req_exc_in, .req_exc_code_in, .interrupt,
        .resp_valid, .resp_ready, .resp_rdata, .resp_exception, .resp_exc_code, .resp_badvaddr,
        .bus_rd_req, .bus_wr_req, .bus_addr, .bus_wstrb, .bus_wdata, .bus_rdata, .bus_data_ok
    );

    always #10 clk = ~clk;

    // untouched words read back as a mix of their own address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h6b3d_91c7;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return fill_word(addr);
    endfunction

    // answers one request at a time after 0 to 3 wait cycles
    always @(posedge clk) begin
        logic [31:0] word;
        #2;
        if (reset) begin
            bus_data_ok = 1'b0;
            pending = 1'b0;
        end else if (bus_data_ok) begin
            bus_data_ok = 1'b0;
        end else if (bus_rd_req || bus_wr_req) begin
            if (!pending) begin
                pending = 1'b1;
                wait_left = $urandom % 4;
            end
            if (wait_left == 0) begin
                pending = 1'b0;
                bus_data_ok = 1'b1;
                word = read_word(bus_addr);
                if (bus_wr_req) begin
                    for (int b = 0; b < 4; b++) begin
                        if (bus_wstrb[b]) begin
                            word[8*b +: 8] = bus_wdata[8*b +: 8];
                        end
                    end
                    mem[bus_addr] = word;
                    wr_count++;
                end else begin
                    bus_rdata = word;
                    rd_count++;
                end
            end else begin
                wait_left--;
            end
        end
    end

    task automatic add_test(
        input string name, input mem_op_e op, input logic [31:0] addr,
        input logic [31:0] wdata, input logic [2:0] faults, input exc_code_e exc_code_in,
        input logic [31:0] exp_data, input logic exp_exc, input exc_code_e exp_code,
        input logic [31:0] exp_badvaddr, input int exp_reads, input int exp_writes,
        input int stall
    );
        test_entry_t t;
        t.name = name;
        t.op = op;
        t.addr = addr;
        t.wdata = wdata;
        t.faults = faults;
        t.exc_code_in = exc_code_in;
        t.exp_data = exp_data;
        t.exp_exc = exp_exc;
        t.exp_code = exp_code;
        t.exp_badvaddr = exp_badvaddr;
        t.exp_reads = exp_reads;
        t.exp_writes = exp_writes;
        t.stall = stall;
        tests.push_back(t);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED at time %0t: test %0d %s: %s is %h, expected %h",
                 $time, cur_index, cur_name, what, got, exp);
        test_bad = 1'b1;
    endtask

    task automatic build_table();
        add_test("uncached sw", op_sw, 32'ha000_0100, 32'h1234_5678, 3'b000, exc_int,
                 32'h0, 1'b0, exc_int, 32'h0, 0, 1, 0);
        add_test("uncached lw", op_lw, 32'ha000_0100, 32'h0, 3'b000, exc_int,
                 32'h1234_5678, 1'b0, exc_int, 32'h0, 1, 0, 0);
        add_test("uncached sb offset 1", op_sb, 32'ha000_0101, 32'h0000_0085, 3'b000, exc_int,
                 32'h0, 1'b0, exc_int, 32'h0, 0, 1, 0);
        add_test("uncached sh offset 2", op_sh, 32'ha000_0102, 32'h0000_9abc, 3'b000, exc_int,
                 32'h0, 1'b0, exc_int, 32'h0, 0, 1, 0);
        add_test("uncached lw merged", op_lw, 32'ha000_0100, 32'h0, 3'b000, exc_int,
                 32'h9abc_8578, 1'b0, exc_int, 32'h0, 1, 0, 0);
        add_test("lb sign extend", op_lb, 32'ha000_0101, 32'h0, 3'b000, exc_int,
                 32'hffff_ff85, 1'b0, exc_int, 32'h0, 1, 0, 0);
        add_test("lbu zero extend", op_lbu, 32'ha000_0101, 32'h0, 3'b000, exc_int,
                 32'h0000_0085, 1'b0, exc_int, 32'h0, 1, 0, 0);
        add_test("lh sign extend", op_lh, 32'ha000_0102, 32'h0, 3'b000, exc_int,
                 32'hffff_9abc, 1'b0, exc_int, 32'h0, 1, 0, 0);
        add_test("lhu zero extend", op_lhu, 32'ha000_0102, 32'h0, 3'b000, exc_int,
                 32'h0000_9abc, 1'b0, exc_int, 32'h0, 1, 0, 0);
        add_test("cached lw miss", op_lw, 32'h8000_0200, 32'h0, 3'b000, exc_int,
                 fill_word(32'h0000_0200), 1'b0, exc_int, 32'h0, 1, 0, 0);
        add_test("cached lw hit", op_lw, 32'h8000_0200, 32'h0, 3'b000, exc_int,
                 fill_word(32'h0000_0200), 1'b0, exc_int, 32'h0, 0, 0, 0);
        add_test("cached sw hit", op_sw, 32'h8000_0200, 32'hcafe_f00d, 3'b000, exc_int,
                 32'h0, 1'b0, exc_int, 32'h0, 0, 1, 0);
        add_test("cached lw after sw", op_lw, 32'h8000_0200, 32'h0, 3'b000, exc_int,
                 32'hcafe_f00d, 1'b0, exc_int, 32'h0, 0, 0, 0);
        add_test("cached sb hit", op_sb, 32'h8000_0203, 32'h0000_0011, 3'b000, exc_int,
                 32'h0, 1'b0, exc_int, 32'h0, 0, 1, 0);
        add_test("cached lw after sb", op_lw, 32'h8000_0200, 32'h0, 3'b000, exc_int,
                 32'h11fe_f00d, 1'b0, exc_int, 32'h0, 0, 0, 0);
        add_test("memory behind cache", op_lw, 32'ha000_0200, 32'h0, 3'b000, exc_int,
                 32'h11fe_f00d, 1'b0, exc_int, 32'h0, 1, 0, 0);
        add_test("interrupt first", op_sh, 32'h8000_0301, 32'h0, 3'b111, exc_adel,
                 32'h0, 1'b1, exc_int, 32'h0, 0, 0, 0);
        add_test("overflow over ades", op_sh, 32'h8000_0301, 32'h0, 3'b011, exc_adel,
                 32'h0, 1'b1, exc_ov, 32'h0, 0, 0, 0);
        add_test("ades over carried", op_sh, 32'h8000_0301, 32'h0, 3'b001, exc_adel,
                 32'h0, 1'b1, exc_ades, 32'h8000_0301, 0, 0, 0);
        add_test("adel over carried", op_lw, 32'h8000_0302, 32'h0, 3'b001, exc_ov,
                 32'h0, 1'b1, exc_adel, 32'h8000_0302, 0, 0, 0);
        add_test("carried exception", op_lw, 32'h8000_0300, 32'h0, 3'b001, exc_ov,
                 32'h0, 1'b1, exc_ov, test_pc, 0, 0, 0);
        add_test("uncached sw misaligned", op_sw, 32'ha000_0102, 32'h5555_aaaa, 3'b000, exc_int,
                 32'h0, 1'b1, exc_ades, 32'ha000_0102, 0, 0, 0);
        add_test("stalled hit", op_lw, 32'h8000_0200, 32'h0, 3'b000, exc_int,
                 32'h11fe_f00d, 1'b0, exc_int, 32'h0, 0, 0, 4);
        add_test("stalled exception", op_lh, 32'h8000_0201, 32'h0, 3'b000, exc_int,
                 32'h0, 1'b1, exc_adel, 32'h8000_0201, 0, 0, 3);
    endtask

    initial begin
        test_entry_t t;
        int rd_before;
        int wr_before;
        int waited;
        logic [31:0] held_data;
        logic held_exc;
        exc_code_e held_code;
        logic [31:0] held_bad;

        void'($urandom(32'h9d43_1244));
        reset = 1'b1;
        req_valid = 1'b0;
        req_op = op_none;
        req_addr = 32'h0;
        req_wdata = 32'h0;
        req_pc = test_pc;
        req_overflow = 1'b0;
        req_exc_in = 1'b0;
        req_exc_code_in = exc_int;
        interrupt = 1'b0;
        resp_ready = 1'b0;
        build_table();

        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        if (!req_ready || resp_valid || bus_rd_req || bus_wr_req) begin
            $display("CHECK FAILED at time %0t: outputs not idle after reset", $time);
            fail_count++;
        end

        for (int i = 0; i < tests.size(); i++) begin
            t = tests[i];
            cur_index = i;
            cur_name = t.name;
            test_bad = 1'b0;
            rd_before = rd_count;
            wr_before = wr_count;
            req_op = t.op;
            req_addr = t.addr;
            req_wdata = t.wdata;
            {interrupt, req_overflow, req_exc_in} = t.faults;
            req_exc_code_in = t.exc_code_in;
            req_valid = 1'b1;

            waited = 0;
            while (!req_ready && waited < wait_limit) begin
                @(posedge clk);
                #2;
                waited++;
            end
            if (!req_ready) begin
                $display("test %0d %s: gave up waiting for req_ready", i, t.name);
                timed_out = 1'b1;
                break;
            end
            @(posedge clk);
            #2;
            req_valid = 1'b0;

            waited = 0;
            while (!resp_valid && waited < wait_limit) begin
                @(posedge clk);
                #2;
                waited++;
            end
            if (!resp_valid) begin
                $display("test %0d %s: gave up waiting for resp_valid", i, t.name);
                timed_out = 1'b1;
                break;
            end

            if (resp_rdata !== t.exp_data) begin
                report_mismatch("rdata", resp_rdata, t.exp_data);
            end
            if (resp_exception !== t.exp_exc) begin
                report_mismatch("exception", {31'b0, resp_exception}, {31'b0, t.exp_exc});
            end
            if (t.exp_exc && resp_exc_code !== t.exp_code) begin
                report_mismatch("exc_code", {27'b0, resp_exc_code}, {27'b0, t.exp_code});
            end
            if (t.exp_exc && resp_badvaddr !== t.exp_badvaddr) begin
                report_mismatch("badvaddr", resp_badvaddr, t.exp_badvaddr);
            end
            if (rd_count - rd_before != t.exp_reads) begin
                report_mismatch("bus reads", rd_count - rd_before, t.exp_reads);
            end
            if (wr_count - wr_before != t.exp_writes) begin
                report_mismatch("bus writes", wr_count - wr_before, t.exp_writes);
            end

            // response must hold while the consumer stalls
            held_data = resp_rdata;
            held_exc = resp_exception;
            held_code = resp_exc_code;
            held_bad = resp_badvaddr;
            for (int s = 0; s < t.stall; s++) begin
                @(posedge clk);
                #2;
                if (!resp_valid) begin
                    report_mismatch("resp_valid in stall", 32'h0, 32'h1);
                end
                if (req_ready) begin
                    report_mismatch("req_ready in stall", 32'h1, 32'h0);
                end
                if (resp_rdata !== held_data || resp_exception !== held_exc
                    || resp_exc_code !== held_code || resp_badvaddr !== held_bad) begin
                    report_mismatch("rdata in stall", resp_rdata, held_data);
                end
            end
            resp_ready = 1'b1;
            @(posedge clk);
            #2;
            resp_ready = 1'b0;

            if (test_bad) begin
                fail_count++;
                $display("test %0d %s: error", i, t.name);
            end else begin
                pass_count++;
                $display("test %0d %s: ok", i, t.name);
            end
        end

        if (timed_out) begin
            fail_count++;
        end
        $display("passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
source/mem_stage_pkg.sv
source/mem_bus_if.sv
source/mem_access_check.sv
source/mem_stage_ctrl.sv
source/data_cache.sv
source/uncache_bridge.sv
source/bus_select.sv
source/mem_stage.sv
bench/mem_stage_tb.sv

// ==== source/bus_select.sv ====
module bus_select
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    mem_bus_if.target             cache_bus,
    mem_bus_if.target             unc_bus,
    output logic                  bus_rd_req,
    output logic                  bus_wr_req,
    output logic [addr_width-1:0] bus_addr,
    output logic [3:0]            bus_wstrb,
    output logic [data_width-1:0] bus_wdata,
    input  logic [data_width-1:0] bus_rdata,
    input  logic                  bus_data_ok
);
    typedef enum logic [1:0] {
        own_none,
        own_cache,
        own_unc
    } owner_e;

    owner_e owner;
    owner_e sel;
    logic cache_req;
    logic unc_req;

    assign cache_req = cache_bus.rd_req | cache_bus.wr_req;
    assign unc_req = unc_bus.rd_req | unc_bus.wr_req;

    always_comb begin
        sel = owner;
        if (owner == own_none) begin
            if (cache_req) begin
                sel = own_cache;
            end else if (unc_req) begin
                sel = own_unc;
            end
        end
    end

    assign bus_rd_req = (sel == own_cache) ? cache_bus.rd_req : (sel == own_unc) && unc_bus.rd_req;
    assign bus_wr_req = (sel == own_cache) ? cache_bus.wr_req : (sel == own_unc) && unc_bus.wr_req;
    assign bus_addr = (sel == own_unc) ? unc_bus.addr : cache_bus.addr;
    assign bus_wstrb = (sel == own_unc) ? unc_bus.wstrb : cache_bus.wstrb;
    assign bus_wdata = (sel == own_unc) ? unc_bus.wdata : cache_bus.wdata;

    assign cache_bus.rdata = (sel == own_cache) ? bus_rdata : '0;
    assign cache_bus.data_ok = (sel == own_cache) && bus_data_ok;
    assign unc_bus.rdata = (sel == own_unc) ? bus_rdata : '0;
    assign unc_bus.data_ok = (sel == own_unc) && bus_data_ok;

    // owner held until the transfer completes
    always_ff @(posedge clk) begin
        if (reset || bus_data_ok) begin
            owner <= own_none;
        end else begin
            owner <= sel;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(cache_req && unc_req))
        else $error("cache and uncached bridge requesting together");

endmodule

// ==== source/data_cache.sv ====
module data_cache
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic [addr_width-1:0] paddr,
    input  logic [data_width-1:0] wdata,
    input  logic [3:0]            wstrb,
    input  logic                  is_store,
    output logic                  done,
    output logic [data_width-1:0] rdata,
    mem_bus_if.client             bus
);
    typedef enum logic [1:0] {
        c_idle,
        c_read,
        c_write
    } cache_state_e;

    cache_state_e state;
    logic [dcache_tag_bits-1:0] tag_mem [dcache_lines];
    logic [data_width-1:0] data_mem [dcache_lines];
    logic [dcache_lines-1:0] valid;
    logic [dcache_index_bits-1:0] index;
    logic [dcache_tag_bits-1:0] tag;
    logic hit;
    logic [data_width-1:0] merged;

    assign index = paddr[dcache_index_bits+1:2];
    assign tag = paddr[addr_width-1 -: dcache_tag_bits];
    assign hit = valid[index] && tag_mem[index] == tag;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : data_mem[index][8*i +: 8];
        end
    end

    assign bus.rd_req = (state == c_read);
    assign bus.wr_req = (state == c_write);
    assign bus.addr = {paddr[addr_width-1:2], 2'b00};
    assign bus.wstrb = wstrb;
    assign bus.wdata = wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= c_idle;
            valid <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                c_idle: begin
                    if (start) begin
                        if (is_store) begin
                            state <= c_write;
                        end else if (hit) begin
                            done <= 1'b1;
                        end else begin
                            state <= c_read;
                        end
                    end
                end
                c_read: begin
                    if (bus.data_ok) begin
                        valid[index] <= 1'b1;
                        done <= 1'b1;
                        state <= c_idle;
                    end
                end
                default: begin
                    if (bus.data_ok) begin
                        done <= 1'b1;
                        state <= c_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == c_idle && start) begin
            rdata <= data_mem[index];
            // write-through, line only updated on a hit
            if (is_store && hit) begin
                data_mem[index] <= merged;
            end
        end
        if (state == c_read && bus.data_ok) begin
            tag_mem[index] <= tag;
            data_mem[index] <= bus.rdata;
            rdata <= bus.rdata;
        end
    end

endmodule

// ==== source/mem_access_check.sv ====
module mem_access_check
    import mem_stage_pkg::*;
(
    input  mem_op_e               op,
    input  logic [addr_width-1:0] vaddr,
    input  logic [addr_width-1:0] pc,
    input  logic                  overflow,
    input  logic                  exc_in,
    input  exc_code_e             exc_code_in,
    input  logic                  interrupt,
    output logic                  exception,
    output exc_code_e             exc_code,
    output logic [addr_width-1:0] badvaddr,
    output logic [addr_width-1:0] paddr,
    output logic                  uncached,
    output logic [3:0]            wstrb,
    output logic                  is_store
);
    logic store_misaligned;
    logic load_misaligned;

    assign is_store = (op == op_sb) || (op == op_sh) || (op == op_sw);

    assign store_misaligned = (op == op_sh && vaddr[0])
                           || (op == op_sw && vaddr[1:0] != 2'b00);
    assign load_misaligned = ((op == op_lh || op == op_lhu) && vaddr[0])
                          || (op == op_lw && vaddr[1:0] != 2'b00);

    assign exception = interrupt | overflow | store_misaligned | load_misaligned | exc_in;

    assign paddr = to_paddr(vaddr);
    assign uncached = in_kseg1(vaddr);

    always_comb begin
        if (interrupt) begin
            exc_code = exc_int;
            badvaddr = '0;
        end else if (overflow) begin
            exc_code = exc_ov;
            badvaddr = '0;
        end else if (store_misaligned) begin
            exc_code = exc_ades;
            badvaddr = vaddr;
        end else if (load_misaligned) begin
            exc_code = exc_adel;
            badvaddr = vaddr;
        end else begin
            // carried from an earlier stage
            exc_code = exc_code_in;
            badvaddr = pc;
        end
    end

    always_comb begin
        wstrb = 4'b0000;
        if (is_store && !exception) begin
            case (op)
                op_sb:   wstrb = 4'b0001 << vaddr[1:0];
                op_sh:   wstrb = vaddr[1] ? 4'b1100 : 4'b0011;
                default: wstrb = 4'b1111;
            endcase
        end
    end

endmodule

// ==== source/mem_bus_if.sv ====
interface mem_bus_if
    import mem_stage_pkg::*;
;
    logic                  rd_req;
    logic                  wr_req;
    logic [addr_width-1:0] addr;
    logic [3:0]            wstrb;
    logic [data_width-1:0] wdata;
    logic [data_width-1:0] rdata;
    logic                  data_ok;

    modport client (
        output rd_req,
        output wr_req,
        output addr,
        output wstrb,
        output wdata,
        input  rdata,
        input  data_ok
    );

    modport target (
        input  rd_req,
        input  wr_req,
        input  addr,
        input  wstrb,
        input  wdata,
        output rdata,
        output data_ok
    );

endinterface

// ==== source/mem_stage.sv ====
module mem_stage
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  mem_op_e               req_op,
    input  logic [addr_width-1:0] req_addr,
    input  logic [data_width-1:0] req_wdata,
    input  logic [addr_width-1:0] req_pc,
    input  logic                  req_overflow,
    input  logic                  req_exc_in,
    input  exc_code_e             req_exc_code_in,
    input  logic                  interrupt,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output logic [data_width-1:0] resp_rdata,
    output logic                  resp_exception,
    output exc_code_e             resp_exc_code,
    output logic [addr_width-1:0] resp_badvaddr,
    output logic                  bus_rd_req,
    output logic                  bus_wr_req,
    output logic [addr_width-1:0] bus_addr,
    output logic [3:0]            bus_wstrb,
    output logic [data_width-1:0] bus_wdata,
    input  logic [data_width-1:0] bus_rdata,
    input  logic                  bus_data_ok
);
    mem_op_e acc_op;
    logic [addr_width-1:0] acc_vaddr;
    logic [data_width-1:0] acc_wdata;
    logic [addr_width-1:0] acc_pc;
    logic acc_overflow;
    logic acc_exc_in;
    exc_code_e acc_exc_code;
    logic acc_interrupt;
    logic exception;
    exc_code_e exc_code;
    logic [addr_width-1:0] badvaddr;
    logic [addr_width-1:0] paddr;
    logic uncached;
    logic [3:0] wstrb;
    logic is_store;
    logic cache_start;
    logic cache_done;
    logic [data_width-1:0] cache_rdata;
    logic unc_start;
    logic unc_done;
    logic [data_width-1:0] unc_rdata;

    mem_bus_if cache_bus ();
    mem_bus_if unc_bus ();

    mem_stage_ctrl u_ctrl (
        .clk, .reset, .req_valid, .req_ready, .req_op, .req_addr, .req_wdata, .req_pc,
        .req_overflow, .req_exc_in, .req_exc_code_in, .interrupt,
        .resp_valid, .resp_ready, .resp_rdata, .resp_exception, .resp_exc_code, .resp_badvaddr,
        .exception, .exc_code, .badvaddr, .uncached,
        .acc_op, .acc_vaddr, .acc_wdata, .acc_pc, .acc_overflow, .acc_exc_in, .acc_exc_code,
        .acc_interrupt, .cache_start, .unc_start,
        .cache_done, .cache_rdata, .unc_done, .unc_rdata
    );

    mem_access_check u_check (
        .op(acc_op), .vaddr(acc_vaddr), .pc(acc_pc), .overflow(acc_overflow),
        .exc_in(acc_exc_in), .exc_code_in(acc_exc_code), .interrupt(acc_interrupt),
        .exception, .exc_code, .badvaddr, .paddr, .uncached, .wstrb, .is_store
    );

    data_cache u_dcache (
        .clk, .reset, .start(cache_start), .paddr, .wdata(acc_wdata), .wstrb, .is_store,
        .done(cache_done), .rdata(cache_rdata), .bus(cache_bus.client)
    );

    uncache_bridge u_uncache (
        .clk, .reset, .start(unc_start), .paddr, .wdata(acc_wdata), .wstrb, .is_store,
        .done(unc_done), .rdata(unc_rdata), .bus(unc_bus.client)
    );

    bus_select u_bus_select (
        .clk, .reset, .cache_bus(cache_bus.target), .unc_bus(unc_bus.target),
        .bus_rd_req, .bus_wr_req, .bus_addr, .bus_wstrb, .bus_wdata, .bus_rdata, .bus_data_ok
    );

endmodule

// ==== source/mem_stage_ctrl.sv ====
module mem_stage_ctrl
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  mem_op_e               req_op,
    input  logic [addr_width-1:0] req_addr,
    input  logic [data_width-1:0] req_wdata,
    input  logic [addr_width-1:0] req_pc,
    input  logic                  req_overflow,
    input  logic                  req_exc_in,
    input  exc_code_e             req_exc_code_in,
    input  logic                  interrupt,
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output logic [data_width-1:0] resp_rdata,
    output logic                  resp_exception,
    output exc_code_e             resp_exc_code,
    output logic [addr_width-1:0] resp_badvaddr,
    input  logic                  exception,
    input  exc_code_e             exc_code,
    input  logic [addr_width-1:0] badvaddr,
    input  logic                  uncached,
    output mem_op_e               acc_op,
    output logic [addr_width-1:0] acc_vaddr,
    output logic [data_width-1:0] acc_wdata,
    output logic [addr_width-1:0] acc_pc,
    output logic                  acc_overflow,
    output logic                  acc_exc_in,
    output exc_code_e             acc_exc_code,
    output logic                  acc_interrupt,
    output logic                  cache_start,
    output logic                  unc_start,
    input  logic                  cache_done,
    input  logic [data_width-1:0] cache_rdata,
    input  logic                  unc_done,
    input  logic [data_width-1:0] unc_rdata
);
    ctrl_state_e state;
    logic started;
    logic launch;
    logic [data_width-1:0] raw;
    logic [data_width-1:0] shifted;
    logic [data_width-1:0] load_data;

    assign req_ready = (state == s_idle);
    assign resp_valid = (state == s_respond);

    // one start pulse in the first access cycle
    assign launch = (state == s_access) && !started && !exception && acc_op != op_none;
    assign cache_start = launch && !uncached;
    assign unc_start = launch && uncached;

    assign raw = uncached ? unc_rdata : cache_rdata;
    assign shifted = raw >> {acc_vaddr[1:0], 3'b000};

    always_comb begin
        case (acc_op)
            op_lb:   load_data = {{24{shifted[7]}}, shifted[7:0]};
            op_lbu:  load_data = {24'h0, shifted[7:0]};
            op_lh:   load_data = {{16{shifted[15]}}, shifted[15:0]};
            op_lhu:  load_data = {16'h0, shifted[15:0]};
            op_lw:   load_data = raw;
            default: load_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
            started <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (req_valid) begin
                        state <= s_access;
                        started <= 1'b0;
                    end
                end
                s_access: begin
                    if (!started) begin
                        if (launch) begin
                            started <= 1'b1;
                        end else begin
                            state <= s_respond;
                        end
                    end else if (cache_done || unc_done) begin
                        state <= s_respond;
                    end
                end
                default: begin
                    if (resp_ready) begin
                        state <= s_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && req_valid) begin
            acc_op <= req_op;
            acc_vaddr <= req_addr;
            acc_pc <= req_pc;
            acc_overflow <= req_overflow;
            acc_exc_in <= req_exc_in;
            acc_exc_code <= req_exc_code_in;
            acc_interrupt <= interrupt;
            // store data copied onto every byte lane
            case (req_op)
                op_sb:   acc_wdata <= {4{req_wdata[7:0]}};
                op_sh:   acc_wdata <= {2{req_wdata[15:0]}};
                default: acc_wdata <= req_wdata;
            endcase
        end
        if (state == s_access && (!started ? !launch : (cache_done || unc_done))) begin
            resp_rdata <= started ? load_data : '0;
            resp_exception <= exception;
            resp_exc_code <= exc_code;
            resp_badvaddr <= badvaddr;
        end
    end

    // a client finishes only while its access is outstanding
    assert property (@(posedge clk) disable iff (reset)
        !((cache_done || unc_done) && !(state == s_access && started)))
        else $error("memory client done outside an access");

endmodule

// ==== source/mem_stage_pkg.sv ====
package mem_stage_pkg;

    localparam int data_width = 32;
    localparam int addr_width = 32;

    // 64 single-word lines
    localparam int dcache_index_bits = 6;
    localparam int dcache_lines = 1 << dcache_index_bits;
    localparam int dcache_tag_bits = addr_width - dcache_index_bits - 2;

    localparam logic [2:0] kseg1_prefix = 3'b101;

    typedef enum logic [3:0] {
        op_none,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_ov   = 5'd12
    } exc_code_e;

    typedef enum logic [1:0] {
        s_idle,
        s_access,
        s_respond
    } ctrl_state_e;

    // fixed mapping, top three bits dropped
    function automatic logic [addr_width-1:0] to_paddr(input logic [addr_width-1:0] vaddr);
        return {3'b000, vaddr[addr_width-4:0]};
    endfunction

    function automatic logic in_kseg1(input logic [addr_width-1:0] vaddr);
        return vaddr[addr_width-1 -: 3] == kseg1_prefix;
    endfunction

endpackage

// ==== source/uncache_bridge.sv ====
module uncache_bridge
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic [addr_width-1:0] paddr,
    input  logic [data_width-1:0] wdata,
    input  logic [3:0]            wstrb,
    input  logic                  is_store,
    output logic                  done,
    output logic [data_width-1:0] rdata,
    mem_bus_if.client             bus
);
    logic busy;

    assign bus.rd_req = busy && !is_store;
    assign bus.wr_req = busy && is_store;
    assign bus.addr = {paddr[addr_width-1:2], 2'b00};
    assign bus.wstrb = wstrb;
    assign bus.wdata = wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
            end else if (busy && bus.data_ok) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // device data only valid in the data_ok cycle
    always_ff @(posedge clk) begin
        if (busy && bus.data_ok) begin
            rdata <= bus.rdata;
        end
    end

endmodule
